/* files.f */
common/sd_pkg.sv
sd/sd_clock_gen.sv
sd/sd_cmd_engine.sv
sd/sd_init_fsm.sv
source/uart_tx.sv
source/sd_init_top.sv
testbench/sd_card_model.sv
testbench/sd_init_tb.sv

/* Makefile */
# Verilator build and run of the SD init testbench

VERILATOR ?= verilator
TOP       ?= sd_init_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/sd_init_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_init_tb;

  localparam int NUM_ROWS = 7;
  // cycles allowed for one whole init run
  localparam int RUN_LIMIT = 4_000_000;

  logic clk;
  logic reset;
  logic sd_miso;
  logic sd_sck;
  logic sd_mosi;
  logic sd_cs;
  logic uart_txd;
  logic init_done;
  logic init_error;
  logic high_capacity;

  // card settings for the current row
  int cfg_busy;
  logic cfg_v1;
  logic cfg_echo;
  int cfg_idle;
  logic cfg_ccs;
  logic cfg_silent;
  int crc_errs;
  logic hcs_bad;

  // uart decoder state
  logic rx_busy;
  int rx_cnt;
  int rx_bit;
  logic [7:0] rx_shift;
  logic [7:0] last_char;
  int s_count;
  int framing_errs;
  int other_chars;

  // one row each for v2 high capacity, v1, v2 standard, bad echo, cmd0 never idle,
  // silent card and acmd41 stuck idle
  int         tab_busy   [NUM_ROWS] = '{2, 0, 0, 0, 255, 0, 0};
  logic       tab_v1     [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
  logic       tab_echo   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
  int         tab_idle   [NUM_ROWS] = '{3, 1, 0, 0, 0, 0, 255};
  logic       tab_ccs    [NUM_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
  logic       tab_silent [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  // expected outcome per row
  logic       tab_done   [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
  logic       tab_hc     [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
  int         tab_s      [NUM_ROWS] = '{14, 8, 6, 2, sd_pkg::CMD0_ATTEMPTS,
                                        sd_pkg::CMD0_ATTEMPTS, 3 + 2 * sd_pkg::ACMD41_ATTEMPTS};
  logic [7:0] tab_last   [NUM_ROWS] = '{"K", "K", "K", "E", "E", "E", "E"};

  sd_init_top UUT (
    .clk           (clk),
    .reset         (reset),
    .sd_miso       (sd_miso),
    .sd_sck        (sd_sck),
    .sd_mosi       (sd_mosi),
    .sd_cs         (sd_cs),
    .uart_txd      (uart_txd),
    .init_done     (init_done),
    .init_error    (init_error),
    .high_capacity (high_capacity)
  );

  sd_card_model card (
    .clk       (clk),
    .reset     (reset),
    .sd_sck    (sd_sck),
    .sd_cs     (sd_cs),
    .sd_mosi   (sd_mosi),
    .sd_miso   (sd_miso),
    .cmd0_busy (cfg_busy),
    .version1  (cfg_v1),
    .bad_echo  (cfg_echo),
    .acmd_idle (cfg_idle),
    .ccs       (cfg_ccs),
    .silent    (cfg_silent),
    .crc_errs  (crc_errs),
    .hcs_bad   (hcs_bad)
  );

  always #2 clk = ~clk;

  // 8N1 decoder sampling each bit at its midpoint
  always @(posedge clk) begin
    if (reset) begin
      rx_busy <= 1'b0;
      rx_cnt <= 0;
      rx_bit <= 0;
      last_char <= 8'h00;
      s_count <= 0;
      framing_errs <= 0;
      other_chars <= 0;
    end else if (!rx_busy) begin
      if (!uart_txd) begin
        rx_busy <= 1'b1;
        rx_cnt <= 0;
        rx_bit <= 0;
      end
    end else begin
      rx_cnt <= rx_cnt + 1;
      if (rx_cnt == sd_pkg::UART_CLKS_PER_BIT / 2 + rx_bit * sd_pkg::UART_CLKS_PER_BIT) begin
        rx_bit <= rx_bit + 1;
        if (rx_bit == 0) begin
          // a glitch rather than a real start bit
          if (uart_txd) rx_busy <= 1'b0;
        end else if (rx_bit <= 8) begin
          rx_shift <= {uart_txd, rx_shift[7:1]};
        end else begin
          rx_busy <= 1'b0;
          if (!uart_txd) framing_errs <= framing_errs + 1;
          last_char <= rx_shift;
          if (rx_shift == "s") s_count <= s_count + 1;
          else if (rx_shift != "K" && rx_shift != "E") other_chars <= other_chars + 1;
        end
      end
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic report_mismatch(input string what, input int got, input int want);
    abort_run($sformatf("Error at time %0t: %s is %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic wait_for_end();
    int cycles;
    cycles = 0;
    while (!(init_done || init_error)) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_LIMIT) abort_run("Timeout: neither init_done nor init_error rose");
    end
  endtask

  // final K or E is still on the line when done rises
  task automatic wait_for_last_char();
    int cycles;
    cycles = 0;
    while (last_char != "K" && last_char != "E") begin
      @(negedge clk);
      cycles++;
      if (cycles > 12 * sd_pkg::UART_CLKS_PER_BIT) abort_run("Timeout: no final trace character");
    end
  endtask

  task automatic wait_sck_level(input logic level, output int cycles);
    cycles = 0;
    while (sd_sck !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4 * sd_pkg::SCK_HALF_SLOW) abort_run("Timeout: sd_sck stopped toggling");
    end
  endtask

  task automatic check_fast_clock();
    int lo;
    int hi;
    @(negedge clk);
    // line up on a rising edge then time one full period
    wait_sck_level(1'b0, lo);
    wait_sck_level(1'b1, hi);
    wait_sck_level(1'b0, lo);
    wait_sck_level(1'b1, hi);
    assert (lo + hi <= 4 * sd_pkg::SCK_HALF_FAST) else
      abort_run($sformatf("Error at time %0t: sd_sck period %0d cycles, limit %0d",
                          $time, lo + hi, 4 * sd_pkg::SCK_HALF_FAST));
  endtask

  task automatic run_row(input int row);
    @(posedge clk);
    reset <= 1'b1;
    cfg_busy <= tab_busy[row];
    cfg_v1 <= tab_v1[row];
    cfg_echo <= tab_echo[row];
    cfg_idle <= tab_idle[row];
    cfg_ccs <= tab_ccs[row];
    cfg_silent <= tab_silent[row];
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (sd_cs && sd_mosi && uart_txd && !init_done && !init_error && !high_capacity) else
      abort_run($sformatf("Error at time %0t: outputs not at reset values, row %0d", $time, row));
    wait_for_end();
    wait_for_last_char();
    assert (init_done == tab_done[row]) else
      report_mismatch("init_done", int'(init_done), int'(tab_done[row]));
    assert (init_error == !tab_done[row]) else
      report_mismatch("init_error", int'(init_error), int'(!tab_done[row]));
    assert (high_capacity == tab_hc[row]) else
      report_mismatch("high_capacity", int'(high_capacity), int'(tab_hc[row]));
    assert (s_count == tab_s[row]) else report_mismatch("count of s", s_count, tab_s[row]);
    assert (last_char == tab_last[row]) else
      report_mismatch("last character", int'(last_char), int'(tab_last[row]));
    assert (crc_errs == 0) else report_mismatch("frames with bad crc7", crc_errs, 0);
    assert (!hcs_bad) else report_mismatch("ACMD41 hcs mismatches", int'(hcs_bad), 0);
    assert (framing_errs == 0 && other_chars == 0) else
      report_mismatch("bad uart characters", framing_errs + other_chars, 0);
    if (tab_done[row]) check_fast_clock();
  endtask

  initial begin
    int row;
    clk = 1'b0;
    reset = 1'b1;
    cfg_busy = 0;
    cfg_v1 = 1'b0;
    cfg_echo = 1'b0;
    cfg_idle = 0;
    cfg_ccs = 1'b0;
    cfg_silent = 1'b0;
    for (row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/sd_card_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
  input  logic clk,
  input  logic reset,
  input  logic sd_sck,
  input  logic sd_cs,
  input  logic sd_mosi,
  output logic sd_miso,
  // card behavior for the current scenario
  input  int   cmd0_busy,
  input  logic version1,
  input  logic bad_echo,
  input  int   acmd_idle,
  input  logic ccs,
  input  logic silent,
  output int   crc_errs,
  output logic hcs_bad
);

  logic sck_q;
  logic rx_active;
  int rx_cnt;
  logic [47:0] rx_bits;
  // pending response, msb leaves first
  logic [47:0] tx_bits;
  int tx_len;
  int cmd0_seen;
  int acmd_seen;
  logic app_cmd;
  logic ready;

  initial sd_miso = 1'b1;

  // serial crc7 with polynomial x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] data);
    logic [6:0] crc;
    logic fb;
    int i;
    crc = 7'd0;
    for (i = 39; i >= 0; i--) begin
      fb = crc[6] ^ data[i];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  task automatic queue_resp(input logic [7:0] r1, input logic long, input logic [31:0] payload);
    // one byte of Ncr gap before R1
    tx_bits <= {8'hFF, r1, payload};
    tx_len <= long ? 48 : 16;
  endtask

  task automatic answer(input sd_pkg::sd_frame_t fr);
    if (silent) begin
      tx_len <= 0;
    end else if (fr.f.start != 2'b01 || !fr.f.stop || crc7_of(fr.raw[47:8]) != fr.f.crc) begin
      // crc error flag plus idle
      crc_errs <= crc_errs + 1;
      queue_resp(8'h09, 1'b0, 32'hFFFF_FFFF);
    end else begin
      app_cmd <= (fr.f.index == sd_pkg::CMD_APP_CMD);
      case (fr.f.index)
        sd_pkg::CMD_GO_IDLE: begin
          cmd0_seen <= cmd0_seen + 1;
          // busy card gives a non-idle R1
          if (cmd0_seen < cmd0_busy) begin
            queue_resp(8'h00, 1'b0, 32'hFFFF_FFFF);
          end else begin
            ready <= 1'b0;
            queue_resp(8'h01, 1'b0, 32'hFFFF_FFFF);
          end
        end
        sd_pkg::CMD_SEND_IF_COND: begin
          // v1 card: illegal command, R1 only
          if (version1) begin
            queue_resp(8'h05, 1'b0, 32'hFFFF_FFFF);
          end else begin
            queue_resp(8'h01, 1'b1, {20'h0, fr.f.arg[11:8],
                                     bad_echo ? ~fr.f.arg[7:0] : fr.f.arg[7:0]});
          end
        end
        sd_pkg::CMD_APP_CMD: queue_resp(ready ? 8'h00 : 8'h01, 1'b0, 32'hFFFF_FFFF);
        sd_pkg::CMD_APP_OP_COND: begin
          if (!app_cmd) begin
            queue_resp(8'h05, 1'b0, 32'hFFFF_FFFF);
          end else begin
            // hcs must be set for v2 only
            if (fr.f.arg[30] == version1) hcs_bad <= 1'b1;
            acmd_seen <= acmd_seen + 1;
            if (acmd_seen < acmd_idle) begin
              queue_resp(8'h01, 1'b0, 32'hFFFF_FFFF);
            end else begin
              ready <= 1'b1;
              queue_resp(8'h00, 1'b0, 32'hFFFF_FFFF);
            end
          end
        end
        // ocr: power-up done, ccs, 2.7-3.6 V window
        sd_pkg::CMD_READ_OCR: queue_resp(ready ? 8'h00 : 8'h01, 1'b1,
                                         {ready, ready & ccs & ~version1, 6'd0, 24'hFF_8000});
        default: queue_resp(8'h05, 1'b0, 32'hFFFF_FFFF);
      endcase
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      sck_q <= 1'b0;
      rx_active <= 1'b0;
      rx_cnt <= 0;
      rx_bits <= '1;
      tx_len <= 0;
      sd_miso <= 1'b1;
      cmd0_seen <= 0;
      acmd_seen <= 0;
      app_cmd <= 1'b0;
      ready <= 1'b0;
      crc_errs <= 0;
      hcs_bad <= 1'b0;
    end else begin
      sck_q <= sd_sck;
      // host bits taken on the rising card clock
      if (sd_sck && !sck_q && !sd_cs) begin
        if (rx_active) begin
          rx_bits <= {rx_bits[46:0], sd_mosi};
          if (rx_cnt == 47) begin
            rx_active <= 1'b0;
            answer({rx_bits[46:0], sd_mosi});
          end else begin
            rx_cnt <= rx_cnt + 1;
          end
        end else if (!sd_mosi) begin
          // first 0 starts a frame
          rx_active <= 1'b1;
          rx_bits <= 48'h0;
          rx_cnt <= 1;
        end
      end
      // response bits change after the falling edge
      if (!sd_sck && sck_q) begin
        if (tx_len > 0) begin
          sd_miso <= tx_bits[47];
          tx_bits <= {tx_bits[46:0], 1'b1};
          tx_len <= tx_len - 1;
        end else begin
          sd_miso <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/sd_init_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_init_top (
  input  logic clk,
  input  logic reset,
  input  logic sd_miso,
  output logic sd_sck,
  output logic sd_mosi,
  output logic sd_cs,
  output logic uart_txd,
  output logic init_done,
  output logic init_error,
  output logic high_capacity
);

  // card clock edges
  logic sck_rise;
  logic sck_fall;
  logic fast_clk;

  // command handshake and response
  logic cmd_valid;
  logic cmd_ready;
  logic [5:0] cmd_index;
  logic [31:0] cmd_arg;
  logic resp_valid;
  logic [7:0] resp_r1;
  logic [31:0] resp_payload;
  logic resp_timeout;

  // trace bytes to the uart
  logic ev_valid;
  logic ev_ready;
  logic [7:0] ev_byte;

  sd_clock_gen u_clock_gen (
    .clk      (clk),
    .reset    (reset),
    .fast_clk (fast_clk),
    .sd_sck   (sd_sck),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall)
  );

  sd_cmd_engine u_cmd_engine (
    .clk          (clk),
    .reset        (reset),
    .sck_rise     (sck_rise),
    .sck_fall     (sck_fall),
    .cmd_valid    (cmd_valid),
    .cmd_index    (cmd_index),
    .cmd_arg      (cmd_arg),
    .sd_miso      (sd_miso),
    .cmd_ready    (cmd_ready),
    .sd_mosi      (sd_mosi),
    .resp_valid   (resp_valid),
    .resp_r1      (resp_r1),
    .resp_payload (resp_payload),
    .resp_timeout (resp_timeout)
  );

  sd_init_fsm u_init_fsm (
    .clk           (clk),
    .reset         (reset),
    .cmd_ready     (cmd_ready),
    .resp_valid    (resp_valid),
    .resp_r1       (resp_r1),
    .resp_payload  (resp_payload),
    .resp_timeout  (resp_timeout),
    .ev_ready      (ev_ready),
    .cmd_valid     (cmd_valid),
    .cmd_index     (cmd_index),
    .cmd_arg       (cmd_arg),
    .sd_cs         (sd_cs),
    .fast_clk      (fast_clk),
    .ev_valid      (ev_valid),
    .ev_byte       (ev_byte),
    .init_done     (init_done),
    .init_error    (init_error),
    .high_capacity (high_capacity)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .ev_valid (ev_valid),
    .ev_byte  (ev_byte),
    .ev_ready (ev_ready),
    .uart_txd (uart_txd)
  );

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       ev_valid,
  input  logic [7:0] ev_byte,
  output logic       ev_ready,
  output logic       uart_txd
);

  logic busy;
  logic [$clog2(sd_pkg::UART_CLKS_PER_BIT)-1:0] clk_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0] bit_idx;
  // data bits then the stop bit, lsb leaves first
  logic [8:0] shifter;

  assign ev_ready = ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      uart_txd <= 1'b1;
    end else if (!busy) begin
      if (ev_valid && ev_ready) begin
        busy <= 1'b1;
        shifter <= {1'b1, ev_byte};
        // start bit
        uart_txd <= 1'b0;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (int'(clk_cnt) == sd_pkg::UART_CLKS_PER_BIT - 1) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        // stop bit done, line stays high
        busy <= 1'b0;
      end else begin
        uart_txd <= shifter[0];
        shifter <= {1'b1, shifter[8:1]};
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sd/sd_init_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_init_fsm (
  input  logic        clk,
  input  logic        reset,
  input  logic        cmd_ready,
  input  logic        resp_valid,
  input  logic [7:0]  resp_r1,
  input  logic [31:0] resp_payload,
  input  logic        resp_timeout,
  input  logic        ev_ready,
  output logic        cmd_valid,
  output logic [5:0]  cmd_index,
  output logic [31:0] cmd_arg,
  output logic        sd_cs,
  output logic        fast_clk,
  output logic        ev_valid,
  output logic [7:0]  ev_byte,
  output logic        init_done,
  output logic        init_error,
  output logic        high_capacity
);

  logic [2:0] phase;
  logic [2:0] step;
  logic [$clog2(sd_pkg::POWER_UP_CYCLES)-1:0] pu_cnt;
  logic [$clog2(sd_pkg::CMD0_ATTEMPTS + sd_pkg::ACMD41_ATTEMPTS)-1:0] tries;
  logic card_v2;
  logic [2:0] go_step;
  logic go_fail;
  logic go_done;

  // command for the current step
  always_comb begin
    cmd_arg = '0;
    case (step)
      sd_pkg::ST_CMD0: cmd_index = sd_pkg::CMD_GO_IDLE;
      sd_pkg::ST_CMD8: begin
        cmd_index = sd_pkg::CMD_SEND_IF_COND;
        cmd_arg = sd_pkg::IF_COND_ARG;
      end
      sd_pkg::ST_CMD55: cmd_index = sd_pkg::CMD_APP_CMD;
      sd_pkg::ST_ACMD41: begin
        cmd_index = sd_pkg::CMD_APP_OP_COND;
        // only v2 cards may be asked for high capacity
        if (card_v2) cmd_arg[sd_pkg::OCR_HCS_BIT] = 1'b1;
      end
      default: cmd_index = sd_pkg::CMD_READ_OCR;
    endcase
  end

  // where a response leads
  always_comb begin
    go_step = step;
    go_fail = 1'b0;
    go_done = 1'b0;
    case (step)
      sd_pkg::ST_CMD0: begin
        if (!resp_timeout && resp_r1 == sd_pkg::R1_IDLE) go_step = sd_pkg::ST_CMD8;
        else if (int'(tries) == sd_pkg::CMD0_ATTEMPTS - 1) go_fail = 1'b1;
      end
      sd_pkg::ST_CMD8: begin
        // v1 rejects CMD8, v2 echoes voltage and pattern
        if (!resp_timeout && (resp_r1 == sd_pkg::R1_ILLEGAL_IDLE ||
            (resp_r1 == sd_pkg::R1_IDLE &&
             resp_payload[11:0] == sd_pkg::IF_COND_ARG[11:0]))) begin
          go_step = sd_pkg::ST_CMD58A;
        end else begin
          go_fail = 1'b1;
        end
      end
      sd_pkg::ST_CMD58A: go_step = sd_pkg::ST_CMD55;
      sd_pkg::ST_CMD55: begin
        if (resp_timeout) go_fail = 1'b1;
        else go_step = sd_pkg::ST_ACMD41;
      end
      sd_pkg::ST_ACMD41: begin
        if (!resp_timeout && resp_r1 == sd_pkg::R1_READY) go_step = sd_pkg::ST_CMD58B;
        else if (!resp_timeout && resp_r1 == sd_pkg::R1_IDLE &&
                 int'(tries) != sd_pkg::ACMD41_ATTEMPTS - 1) go_step = sd_pkg::ST_CMD55;
        else go_fail = 1'b1;
      end
      default: go_done = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= sd_pkg::PH_POWER;
      step <= sd_pkg::ST_CMD0;
      pu_cnt <= '0;
      tries <= '0;
      card_v2 <= 1'b0;
      cmd_valid <= 1'b0;
      ev_valid <= 1'b0;
      sd_cs <= 1'b1;
      fast_clk <= 1'b0;
      init_done <= 1'b0;
      init_error <= 1'b0;
      high_capacity <= 1'b0;
    end else begin
      case (phase)
        sd_pkg::PH_POWER: begin
          // card needs clocks with cs high before CMD0
          if (int'(pu_cnt) == sd_pkg::POWER_UP_CYCLES - 1) begin
            sd_cs <= 1'b0;
            ev_valid <= 1'b1;
            ev_byte <= sd_pkg::EV_CMD;
            phase <= sd_pkg::PH_EVENT;
          end else begin
            pu_cnt <= pu_cnt + 1'b1;
          end
        end
        sd_pkg::PH_EVENT: begin
          // trace byte goes first, command waits on the uart
          if (ev_ready) begin
            ev_valid <= 1'b0;
            cmd_valid <= 1'b1;
            phase <= sd_pkg::PH_ISSUE;
          end
        end
        sd_pkg::PH_ISSUE: begin
          if (cmd_ready) begin
            cmd_valid <= 1'b0;
            phase <= sd_pkg::PH_WAIT;
          end
        end
        sd_pkg::PH_WAIT: begin
          if (resp_valid) begin
            if (step == sd_pkg::ST_CMD8) card_v2 <= (resp_r1 == sd_pkg::R1_IDLE);
            if (step == sd_pkg::ST_CMD58B) begin
              high_capacity <= resp_payload[sd_pkg::OCR_HCS_BIT];
              fast_clk <= 1'b1;
            end
            // one counter serves CMD0 tries and then ACMD41 pairs
            if (step == sd_pkg::ST_CMD0 && go_step == sd_pkg::ST_CMD8) begin
              tries <= '0;
            end else if (step == sd_pkg::ST_CMD0 || step == sd_pkg::ST_ACMD41) begin
              tries <= tries + 1'b1;
            end
            ev_valid <= 1'b1;
            if (go_fail || go_done) begin
              ev_byte <= go_done ? sd_pkg::EV_OK : sd_pkg::EV_FAIL;
              phase <= sd_pkg::PH_FINAL;
            end else begin
              ev_byte <= sd_pkg::EV_CMD;
              step <= go_step;
              phase <= sd_pkg::PH_EVENT;
            end
          end
        end
        sd_pkg::PH_FINAL: begin
          if (ev_ready) begin
            ev_valid <= 1'b0;
            init_done <= (ev_byte == sd_pkg::EV_OK);
            init_error <= (ev_byte != sd_pkg::EV_OK);
            phase <= sd_pkg::PH_HALT;
          end
        end
        // halted until the next reset
        default: phase <= sd_pkg::PH_HALT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sd/sd_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_engine (
  input  logic        clk,
  input  logic        reset,
  input  logic        sck_rise,
  input  logic        sck_fall,
  input  logic        cmd_valid,
  input  logic [5:0]  cmd_index,
  input  logic [31:0] cmd_arg,
  input  logic        sd_miso,
  output logic        cmd_ready,
  output logic        sd_mosi,
  output logic        resp_valid,
  output logic [7:0]  resp_r1,
  output logic [31:0] resp_payload,
  output logic        resp_timeout
);

  logic [1:0] state;
  sd_pkg::sd_frame_t frame;
  logic [6:0] crc;
  logic [5:0] bit_cnt;
  logic [5:0] rx_cnt;
  logic [38:0] rx;
  logic long_resp;
  logic [$clog2(sd_pkg::RESP_TIMEOUT_BITS)-1:0] tout_cnt;
  logic in_crc;

  // one bit of crc7, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_step(input logic [6:0] c, input logic b);
    logic fb;
    fb = c[6] ^ b;
    return {c[5:3], c[2] ^ fb, c[1:0], fb};
  endfunction

  assign cmd_ready = (state == sd_pkg::ENG_IDLE);
  // bits 40..46 carry the computed crc instead of the frame field
  assign in_crc = (bit_cnt >= 6'd40) && (bit_cnt <= 6'd46);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sd_pkg::ENG_IDLE;
      sd_mosi <= 1'b1;
      resp_valid <= 1'b0;
      bit_cnt <= '0;
      rx_cnt <= '0;
      tout_cnt <= '0;
      crc <= '0;
      long_resp <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      case (state)
        sd_pkg::ENG_IDLE: begin
          if (cmd_valid) begin
            frame.f.start <= 2'b01;
            frame.f.index <= cmd_index;
            frame.f.arg <= cmd_arg;
            frame.f.crc <= 7'd0;
            frame.f.stop <= 1'b1;
            crc <= '0;
            bit_cnt <= '0;
            // R7 and R3 carry 32 bits after R1
            long_resp <= (cmd_index == sd_pkg::CMD_SEND_IF_COND) ||
                         (cmd_index == sd_pkg::CMD_READ_OCR);
            state <= sd_pkg::ENG_SEND;
          end
        end
        sd_pkg::ENG_SEND: begin
          // card samples mosi on the rising edge
          if (sck_fall) begin
            if (in_crc) begin
              sd_mosi <= crc[6];
              crc <= {crc[5:0], 1'b0};
            end else begin
              sd_mosi <= frame.raw[47];
              if (bit_cnt < 6'd40) begin
                crc <= crc7_step(crc, frame.raw[47]);
              end
            end
            frame.raw <= {frame.raw[46:0], 1'b1};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'd47) begin
              tout_cnt <= '0;
              state <= sd_pkg::ENG_WAIT;
            end
          end
        end
        sd_pkg::ENG_WAIT: begin
          if (sck_rise) begin
            if (!sd_miso) begin
              // start bit is the msb of R1
              rx <= {rx[37:0], 1'b0};
              rx_cnt <= 6'd1;
              state <= sd_pkg::ENG_RECV;
            end else if (int'(tout_cnt) == sd_pkg::RESP_TIMEOUT_BITS - 1) begin
              resp_valid <= 1'b1;
              resp_timeout <= 1'b1;
              resp_r1 <= 8'hFF;
              resp_payload <= '0;
              state <= sd_pkg::ENG_IDLE;
            end else begin
              tout_cnt <= tout_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (sck_rise) begin
            if (rx_cnt == (long_resp ? 6'd39 : 6'd7)) begin
              // last bit goes straight into the outputs
              resp_valid <= 1'b1;
              resp_timeout <= 1'b0;
              if (long_resp) begin
                resp_r1 <= rx[38:31];
                resp_payload <= {rx[30:0], sd_miso};
              end else begin
                resp_r1 <= {rx[6:0], sd_miso};
                resp_payload <= '0;
              end
              state <= sd_pkg::ENG_IDLE;
            end else begin
              rx <= {rx[37:0], sd_miso};
              rx_cnt <= rx_cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* sd/sd_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_clock_gen (
  input  logic clk,
  input  logic reset,
  input  logic fast_clk,
  output logic sd_sck,
  output logic sck_rise,
  output logic sck_fall
);

  // sized for the slow half period, the fast one fits easily
  logic [$clog2(sd_pkg::SCK_HALF_SLOW)-1:0] count;
  // rate in use, picked up only at a toggle
  logic fast_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      fast_sel <= 1'b0;
      sd_sck <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      if (int'(count) == (fast_sel ? sd_pkg::SCK_HALF_FAST : sd_pkg::SCK_HALF_SLOW) - 1) begin
        count <= '0;
        sd_sck <= ~sd_sck;
        // strobe lines up with the new sck level
        sck_rise <= ~sd_sck;
        sck_fall <= sd_sck;
        fast_sel <= fast_clk;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* common/sd_pkg.sv */
`default_nettype none

package sd_pkg;

  // system clock and card clock ratios
  localparam int SYS_CLK_HZ = 100_000_000;
  // 400 kHz during init
  localparam int SCK_HALF_SLOW = SYS_CLK_HZ / (2 * 400_000);
  // 25 MHz once the card is ready
  localparam int SCK_HALF_FAST = SYS_CLK_HZ / (2 * 25_000_000);

  // cs high with clock running before CMD0
  localparam int POWER_UP_CYCLES = 100_000;
  // card clock bits to wait for a response start bit
  localparam int RESP_TIMEOUT_BITS = 100;
  localparam int CMD0_ATTEMPTS = 10;
  localparam int ACMD41_ATTEMPTS = 10;

  // 115200 baud, 8N1
  localparam int UART_CLKS_PER_BIT = SYS_CLK_HZ / 115_200;

  // command indices
  localparam logic [5:0] CMD_GO_IDLE = 6'd0;
  localparam logic [5:0] CMD_SEND_IF_COND = 6'd8;
  localparam logic [5:0] CMD_APP_CMD = 6'd55;
  localparam logic [5:0] CMD_APP_OP_COND = 6'd41;
  localparam logic [5:0] CMD_READ_OCR = 6'd58;

  // voltage range 2.7-3.6 V, check pattern AA
  localparam logic [31:0] IF_COND_ARG = 32'h0000_01AA;
  // HCS in the ACMD41 argument, CCS in the OCR
  localparam int OCR_HCS_BIT = 30;

  // R1 responses
  localparam logic [7:0] R1_READY = 8'h00;
  localparam logic [7:0] R1_IDLE = 8'h01;
  localparam logic [7:0] R1_ILLEGAL_IDLE = 8'h05;

  // serial trace characters
  localparam logic [7:0] EV_CMD = 8'h73;
  localparam logic [7:0] EV_OK = 8'h4B;
  localparam logic [7:0] EV_FAIL = 8'h45;

  // command engine states
  localparam logic [1:0] ENG_IDLE = 2'd0;
  localparam logic [1:0] ENG_SEND = 2'd1;
  localparam logic [1:0] ENG_WAIT = 2'd2;
  localparam logic [1:0] ENG_RECV = 2'd3;

  // init sequencer phases
  localparam logic [2:0] PH_POWER = 3'd0;
  localparam logic [2:0] PH_EVENT = 3'd1;
  localparam logic [2:0] PH_ISSUE = 3'd2;
  localparam logic [2:0] PH_WAIT = 3'd3;
  localparam logic [2:0] PH_FINAL = 3'd4;
  localparam logic [2:0] PH_HALT = 3'd5;

  // init sequencer steps, one per command
  localparam logic [2:0] ST_CMD0 = 3'd0;
  localparam logic [2:0] ST_CMD8 = 3'd1;
  localparam logic [2:0] ST_CMD58A = 3'd2;
  localparam logic [2:0] ST_CMD55 = 3'd3;
  localparam logic [2:0] ST_ACMD41 = 3'd4;
  localparam logic [2:0] ST_CMD58B = 3'd5;

  // 48-bit SPI command frame, MSB goes out first
  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  index;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        stop;
  } sd_cmd_fields_t;

  typedef union packed {
    sd_cmd_fields_t f;
    logic [47:0]    raw;
  } sd_frame_t;

endpackage

`default_nettype wire
